// ==== rtl/memory_game_pkg.sv ====
// Memory game shared types
package memory_game_pkg;

    // --------------------
    // Widths
    // --------------------
    typedef logic [3:0] step_t;
    typedef logic [3:0] color_t;
    // Segment a sits in bit 0, g in bit 6
    typedef logic [6:0] seg_t;

    // Stored game sequence, one-hot colors, one per step
    localparam color_t SEQ_TABLE [16] = '{
        4'b0001, 4'b0100, 4'b0010, 4'b1000,
        4'b0100, 4'b0001, 4'b1000, 4'b0010,
        4'b0010, 4'b1000, 4'b0001, 4'b0100,
        4'b1000, 4'b0010, 4'b0100, 4'b0001
    };

    // --------------------
    // Control states
    // --------------------
    typedef enum logic [3:0] {
        idle       = 4'd0,
        prep_round = 4'd1,
        led_show   = 4'd2,
        led_gap    = 4'd3,
        next_led   = 4'd4,
        wait_play  = 4'd5,
        check_play = 4'd6,
        next_step  = 4'd7,
        next_round = 4'd8,
        won        = 4'd10,
        lost       = 4'd11,
        timed_out  = 4'd12
    } game_state_t;

    // Commands from control to datapath
    typedef struct packed {
        logic clr_round;
        logic inc_round;
        logic clr_step;
        logic inc_step;
        logic load_play;
        logic clr_resp_timer;
        logic run_resp_timer;
        logic clr_led_timer;
        logic run_led_timer;
        logic show_led;
    } dp_ctrl_t;

    // Flags from datapath back to control
    typedef struct packed {
        logic play_seen;
        logic play_match;
        logic step_is_round;
        logic round_is_last;
        logic resp_expired;
        logic led_slot_done;
    } dp_status_t;

endpackage

// ==== rtl/sequence_rom.sv ====
// Color sequence ROM
module sequence_rom
    import memory_game_pkg::*;
(
    input  step_t  addr,
    output color_t color
);

    // Combinational lookup, one entry per step
    always_comb begin
        unique case (addr)
            4'd0:    color = SEQ_TABLE[0];
            4'd1:    color = SEQ_TABLE[1];
            4'd2:    color = SEQ_TABLE[2];
            4'd3:    color = SEQ_TABLE[3];
            4'd4:    color = SEQ_TABLE[4];
            4'd5:    color = SEQ_TABLE[5];
            4'd6:    color = SEQ_TABLE[6];
            4'd7:    color = SEQ_TABLE[7];
            4'd8:    color = SEQ_TABLE[8];
            4'd9:    color = SEQ_TABLE[9];
            4'd10:   color = SEQ_TABLE[10];
            4'd11:   color = SEQ_TABLE[11];
            4'd12:   color = SEQ_TABLE[12];
            4'd13:   color = SEQ_TABLE[13];
            4'd14:   color = SEQ_TABLE[14];
            default: color = SEQ_TABLE[15];
        endcase
    end

endmodule

// ==== rtl/game_datapath.sv ====
// Memory game datapath
module game_datapath
    import memory_game_pkg::*;
#(
    parameter int unsigned ROUNDS      = 8,
    parameter int unsigned RESP_CYCLES = 5000,
    parameter int unsigned LED_CYCLES  = 1000
) (
    input  logic       clock,
    input  logic       arst_n,
    input  color_t     buttons,
    input  dp_ctrl_t   ctrl,
    output dp_status_t status,
    output color_t     leds,
    output step_t      round,
    output step_t      step
);

    localparam int unsigned RESP_W = $clog2(RESP_CYCLES + 1);
    localparam int unsigned LED_W  = $clog2(LED_CYCLES + 1);

    color_t            buttons_q;
    color_t            play_q;
    color_t            item;
    logic [RESP_W-1:0] resp_cnt;
    logic [LED_W-1:0]  led_cnt;

    // Stored item at the current step
    sequence_rom u_rom (
        .addr  ( step ),
        .color ( item )
    );

    // --------------------
    // Round and step counters
    // --------------------
    // Round holds the index of the last item played this round, so round 0 is the first
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            round <= '0;
            step  <= '0;
        end else begin
            if (ctrl.clr_round) begin
                round <= '0;
            end else if (ctrl.inc_round) begin
                round <= round + step_t'(1);
            end
            if (ctrl.clr_step) begin
                step <= '0;
            end else if (ctrl.inc_step) begin
                step <= step + step_t'(1);
            end
        end
    end

    // --------------------
    // Press capture
    // --------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            buttons_q <= '0;
        end else begin
            buttons_q <= buttons;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.load_play) begin
            play_q <= buttons;
        end
    end

    // --------------------
    // Timers
    // --------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            resp_cnt <= '0;
            led_cnt  <= '0;
        end else begin
            if (ctrl.clr_resp_timer) begin
                resp_cnt <= '0;
            end else if (ctrl.run_resp_timer) begin
                resp_cnt <= resp_cnt + 1'b1;
            end
            if (ctrl.clr_led_timer) begin
                led_cnt <= '0;
            end else if (ctrl.run_led_timer) begin
                led_cnt <= led_cnt + 1'b1;
            end
        end
    end

    // Status back to control
    always_comb begin
        // Rising edge of any button out of the all-released state
        status.play_seen     = (buttons != '0) && (buttons_q == '0);
        status.play_match    = (play_q == item);
        status.step_is_round = (step == round);
        status.round_is_last = (round == step_t'(ROUNDS - 1));
        status.resp_expired  = (resp_cnt == RESP_W'(RESP_CYCLES - 1));
        status.led_slot_done = (led_cnt == LED_W'(LED_CYCLES - 1));
    end

    assign leds = ctrl.show_led ? item : '0;

    // Control must never let the step run past the current round
    a_step_within_round: assert property (
        @(posedge clock) disable iff (!arst_n) step <= round
    ) else $error("step index is past the round index");

endmodule

// ==== rtl/game_control.sv ====
// Memory game control FSM
module game_control
    import memory_game_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  logic        start,
    input  dp_status_t  status,
    output dp_ctrl_t    ctrl,
    output logic        won,
    output logic        lost,
    output logic        timed_out,
    output logic        done,
    output game_state_t state
);

    game_state_t state_next;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // --------------------
    // Next state and commands
    // --------------------
    always_comb begin
        state_next = state;
        ctrl       = '0;
        unique case (state)
            // Start also restarts from any outcome state
            idle, memory_game_pkg::won, memory_game_pkg::lost,
            memory_game_pkg::timed_out: begin
                if (start) begin
                    ctrl.clr_round = 1'b1;
                    ctrl.clr_step  = 1'b1;
                    state_next     = prep_round;
                end
            end
            prep_round: begin
                ctrl.clr_step      = 1'b1;
                ctrl.clr_led_timer = 1'b1;
                state_next         = led_show;
            end
            // next_led is the first lit cycle of the following item
            led_show, next_led: begin
                ctrl.show_led = 1'b1;
                if (status.led_slot_done) begin
                    ctrl.clr_led_timer = 1'b1;
                    state_next         = led_gap;
                end else begin
                    ctrl.run_led_timer = 1'b1;
                    state_next         = led_show;
                end
            end
            led_gap: begin
                if (status.led_slot_done) begin
                    ctrl.clr_led_timer = 1'b1;
                    if (status.step_is_round) begin
                        ctrl.clr_step       = 1'b1;
                        ctrl.clr_resp_timer = 1'b1;
                        state_next          = wait_play;
                    end else begin
                        ctrl.inc_step = 1'b1;
                        state_next    = next_led;
                    end
                end else begin
                    ctrl.run_led_timer = 1'b1;
                end
            end
            wait_play: begin
                if (status.play_seen) begin
                    ctrl.load_play      = 1'b1;
                    ctrl.clr_resp_timer = 1'b1;
                    state_next          = check_play;
                end else if (status.resp_expired) begin
                    state_next = memory_game_pkg::timed_out;
                end else begin
                    ctrl.run_resp_timer = 1'b1;
                end
            end
            check_play: begin
                if (!status.play_match) begin
                    state_next = memory_game_pkg::lost;
                end else if (!status.step_is_round) begin
                    state_next = next_step;
                end else if (status.round_is_last) begin
                    state_next = memory_game_pkg::won;
                end else begin
                    state_next = next_round;
                end
            end
            next_step: begin
                ctrl.inc_step = 1'b1;
                state_next    = wait_play;
            end
            next_round: begin
                ctrl.inc_round = 1'b1;
                state_next     = prep_round;
            end
            default: state_next = idle;
        endcase
    end

    // --------------------
    // Outcome outputs
    // --------------------
    // Taken from the next state so the flags line up with the state register
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            won       <= 1'b0;
            lost      <= 1'b0;
            timed_out <= 1'b0;
            done      <= 1'b0;
        end else begin
            won       <= (state_next == memory_game_pkg::won);
            lost      <= (state_next == memory_game_pkg::lost) ||
                         (state_next == memory_game_pkg::timed_out);
            timed_out <= (state_next == memory_game_pkg::timed_out);
            done      <= (state_next == memory_game_pkg::won) ||
                         (state_next == memory_game_pkg::lost) ||
                         (state_next == memory_game_pkg::timed_out);
        end
    end

    a_outcome_exclusive: assert property (
        @(posedge clock) disable iff (!arst_n) !(won && lost)
    ) else $error("won and lost raised together");

endmodule

// ==== rtl/hex7seg.sv ====
// Hex digit to seven-segment decoder
module hex7seg
    import memory_game_pkg::*;
(
    input  step_t digit,
    output seg_t  seg
);

    // Active high, bit order g f e d c b a
    always_comb begin
        unique case (digit)
            4'h0:    seg = 7'h3f;
            4'h1:    seg = 7'h06;
            4'h2:    seg = 7'h5b;
            4'h3:    seg = 7'h4f;
            4'h4:    seg = 7'h66;
            4'h5:    seg = 7'h6d;
            4'h6:    seg = 7'h7d;
            4'h7:    seg = 7'h07;
            4'h8:    seg = 7'h7f;
            4'h9:    seg = 7'h6f;
            4'ha:    seg = 7'h77;
            // Lower case b and d keep them apart from 8 and 0
            4'hb:    seg = 7'h7c;
            4'hc:    seg = 7'h39;
            4'hd:    seg = 7'h5e;
            4'he:    seg = 7'h79;
            default: seg = 7'h71;
        endcase
    end

endmodule

// ==== rtl/memory_game.sv ====
// Memory game top level
module memory_game
    import memory_game_pkg::*;
#(
    parameter int unsigned ROUNDS      = 8,
    parameter int unsigned RESP_CYCLES = 5000,
    parameter int unsigned LED_CYCLES  = 1000
) (
    input  logic   clock,
    input  logic   arst_n,
    input  logic   start,
    input  color_t buttons,
    output logic   won,
    output logic   lost,
    output logic   timed_out,
    output logic   done,
    output color_t leds,
    output seg_t   db_state,
    output seg_t   db_round,
    output seg_t   db_step
);

    dp_ctrl_t    ctrl;
    dp_status_t  status;
    step_t       round;
    step_t       step;
    game_state_t state;

    game_datapath #(
        .ROUNDS      ( ROUNDS      ),
        .RESP_CYCLES ( RESP_CYCLES ),
        .LED_CYCLES  ( LED_CYCLES  )
    ) u_datapath (
        .clock   ( clock   ),
        .arst_n  ( arst_n  ),
        .buttons ( buttons ),
        .ctrl    ( ctrl    ),
        .status  ( status  ),
        .leds    ( leds    ),
        .round   ( round   ),
        .step    ( step    )
    );

    game_control u_control (
        .clock     ( clock     ),
        .arst_n    ( arst_n    ),
        .start     ( start     ),
        .status    ( status    ),
        .ctrl      ( ctrl      ),
        .won       ( won       ),
        .lost      ( lost      ),
        .timed_out ( timed_out ),
        .done      ( done      ),
        .state     ( state     )
    );

    // --------------------
    // Debug displays
    // --------------------
    hex7seg u_hex_state (
        .digit ( step_t'(state) ),
        .seg   ( db_state       )
    );

    hex7seg u_hex_round (
        .digit ( round    ),
        .seg   ( db_round )
    );

    hex7seg u_hex_step (
        .digit ( step    ),
        .seg   ( db_step )
    );

endmodule

// ==== tb/memory_game_tb.sv ====
// Memory game testbench
module memory_game_tb
    import memory_game_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned ROUNDS       = 4;
    localparam int unsigned RESP_CYCLES  = 60;
    localparam int unsigned LED_CYCLES   = 3;
    localparam int unsigned CLK_PERIOD   = 4;
    localparam int unsigned RESET_CYCLES = 16;
    localparam int unsigned SEED         = 30873;
    localparam int          NUM_ROWS     = 4;

    // Private copy of the display glyphs, segment a in bit 0
    localparam seg_t GLYPHS [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    // --------------------
    // Scenario table
    // --------------------
    typedef enum logic [1:0] {
        fault_none,
        fault_wrong,
        fault_silent
    } fault_t;

    // Outcome bits in the order won, lost, timed_out, done
    typedef struct packed {
        step_t      rounds_ok;
        fault_t     fault;
        logic [3:0] outcome;
        step_t      end_state;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{4'd4, fault_none,   4'b1001, 4'd10},
        '{4'd1, fault_wrong,  4'b0101, 4'd11},
        '{4'd2, fault_silent, 4'b0111, 4'd12},
        '{4'd4, fault_none,   4'b1001, 4'd10}
    };

    string row_names [NUM_ROWS] = '{
        "win_all", "wrong_in_round2", "silent_in_round3", "win_after_restart"
    };

    logic   clock = 1'b0;
    logic   arst_n;
    logic   start;
    color_t buttons;
    logic   won;
    logic   lost;
    logic   timed_out;
    logic   done;
    color_t leds;
    seg_t   db_state;
    seg_t   db_round;
    seg_t   db_step;

    // Colors seen on the LEDs in the current round
    color_t seen [$];

    memory_game #(
        .ROUNDS      ( ROUNDS      ),
        .RESP_CYCLES ( RESP_CYCLES ),
        .LED_CYCLES  ( LED_CYCLES  )
    ) DUT (
        .clock     ( clock     ),
        .arst_n    ( arst_n    ),
        .start     ( start     ),
        .buttons   ( buttons   ),
        .won       ( won       ),
        .lost      ( lost      ),
        .timed_out ( timed_out ),
        .done      ( done      ),
        .leds      ( leds      ),
        .db_state  ( db_state  ),
        .db_round  ( db_round  ),
        .db_step   ( db_step   )
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // --------------------
    // Reporting and compares
    // --------------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_color(input string name, input color_t expected, input color_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_seg(input string name, input seg_t expected, input seg_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_flags(input string name, input logic [3:0] expected,
                               input logic [3:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // --------------------
    // Player model
    // --------------------
    function automatic int played_rounds(input int row);
        return ROWS[row].rounds_ok + ((ROWS[row].fault != fault_none) ? 1 : 0);
    endfunction

    function automatic color_t wrong_color(input color_t right);
        color_t others [$];
        for (int b = 0; b < 4; b++) begin
            if (color_t'(1 << b) != right) begin
                others.push_back(color_t'(1 << b));
            end
        end
        return others[$urandom % others.size()];
    endfunction

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    // Each item lit for LED_CYCLES samples, then dark for LED_CYCLES
    task automatic watch_playback(input string name, input int round_no);
        seen.delete();
        while (leds == '0) @(negedge clock);
        for (int i = 0; i < round_no; i++) begin
            seen.push_back(leds);
            for (int c = 0; c < LED_CYCLES; c++) begin
                check_color($sformatf("%s round %0d item %0d lit", name, round_no, i),
                            SEQ_TABLE[i], leds);
                @(negedge clock);
            end
            for (int c = 0; c < LED_CYCLES; c++) begin
                check_color($sformatf("%s round %0d item %0d gap", name, round_no, i),
                            4'b0000, leds);
                @(negedge clock);
            end
        end
    endtask

    task automatic wait_for_play();
        while (db_state !== GLYPHS[wait_play]) @(negedge clock);
    endtask

    task automatic press_color(input color_t c);
        buttons = c;
        @(negedge clock);
        buttons = '0;
    endtask

    task automatic play_row(input int row);
        string name;
        int    delay;
        name = row_names[row];
        pulse_start();
        check_flags({name, " flags after start"}, 4'b0000, {won, lost, timed_out, done});
        for (int r = 1; r <= played_rounds(row); r++) begin
            watch_playback(name, r);
            for (int s = 0; s < r; s++) begin
                wait_for_play();
                // Round register counts from zero
                check_seg($sformatf("%s db_round r%0d", name, r), GLYPHS[r - 1], db_round);
                check_seg($sformatf("%s db_step s%0d", name, s), GLYPHS[s], db_step);
                delay = $urandom % 4;
                repeat (delay) @(negedge clock);
                if (r > ROWS[row].rounds_ok && s == r - 1) begin
                    if (ROWS[row].fault == fault_wrong) begin
                        press_color(wrong_color(seen[s]));
                    end
                end else begin
                    press_color(seen[s]);
                end
            end
        end
        while (!done) @(negedge clock);
        check_flags({name, " outcome"}, ROWS[row].outcome, {won, lost, timed_out, done});
        check_color({name, " leds at outcome"}, 4'b0000, leds);
        check_seg({name, " db_state at outcome"}, GLYPHS[ROWS[row].end_state], db_state);
        // Outcome must hold until the next start
        repeat (8) @(negedge clock);
        check_flags({name, " outcome held"}, ROWS[row].outcome, {won, lost, timed_out, done});
    endtask

    // --------------------
    // Watchdog
    // --------------------
    function automatic longint watchdog_limit();
        longint total;
        longint per_round;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += played_rounds(i);
        end
        per_round = ROUNDS * 2 * LED_CYCLES + ROUNDS * (RESP_CYCLES + 8) + 16;
        return (RESET_CYCLES + 2 * total * per_round) * CLK_PERIOD;
    endfunction

    initial begin : watchdog
        #(watchdog_limit());
        abort_run("Timeout: the game did not reach the expected point in time");
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        void'($urandom(SEED));
        arst_n  = 1'b0;
        start   = 1'b0;
        buttons = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        check_flags("reset flags", 4'b0000, {won, lost, timed_out, done});
        check_color("reset leds", 4'b0000, leds);
        check_seg("reset db_state", GLYPHS[0], db_state);
        check_seg("reset db_round", GLYPHS[0], db_round);
        check_seg("reset db_step", GLYPHS[0], db_step);
        for (int row = 0; row < NUM_ROWS; row++) begin
            play_row(row);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/memory_game_pkg.sv
rtl/sequence_rom.sv
rtl/game_datapath.sv
rtl/game_control.sv
rtl/hex7seg.sv
rtl/memory_game.sv
tb/memory_game_tb.sv

// ==== Bender.yml ====
package:
  name: memory_game

sources:
  - files:
      - rtl/memory_game_pkg.sv
      - rtl/sequence_rom.sv
      - rtl/game_datapath.sv
      - rtl/game_control.sv
      - rtl/hex7seg.sv
      - rtl/memory_game.sv
  - target: simulation
    files:
      - tb/memory_game_tb.sv

export_include_dirs: []

top: memory_game_tb
